/* source/mem_share_pkg.sv */
package mem_share_pkg;

    // display fetch states
    typedef enum logic [1:0] {
        INACTIVE = 2'd0,
        READY    = 2'd1,
        ACTIVE   = 2'd2
    } vga_state_t;

    // memory slot owners
    typedef enum logic [1:0] {
        VGA       = 2'd0,
        CPU_INSTR = 2'd2,
        CPU_DATA  = 2'd3
    } client_t;

    // request as seen by the shared memory
    typedef struct packed {
        logic        read;
        logic        write;
        logic [31:0] adr;
        logic [31:0] wdata;
        logic [3:0]  sel;
    } mem_req_t;

    // cpu side inputs of the instruction and data ports
    typedef struct packed {
        logic [31:0] instr_adr;
        logic [31:0] data_adr;
        logic        read;
        logic        write;
        logic [31:0] wdata;
        logic [3:0]  sel;
    } cpu_req_t;

    localparam logic [31:0] UART_ADDRESS = 32'd500;

    localparam int MEM_WORDS = 256;
    localparam int MEM_AW    = $clog2(MEM_WORDS);

    localparam int FIFO_DEPTH = 8;
    localparam int FIFO_PW    = $clog2(FIFO_DEPTH);
    localparam int FIFO_CW    = $clog2(FIFO_DEPTH + 1);

    localparam int          FRAME_WORDS = 16;
    localparam int          FRAME_CW    = $clog2(FRAME_WORDS + 1);
    localparam logic [31:0] FRAME_BASE  = 32'h100;
    // first byte address past the frame
    localparam logic [31:0] FRAME_END   = FRAME_BASE + 32'(FRAME_WORDS * 4);

endpackage

/* source/uart_rx_word.sv */
`timescale 1ns/1ps

module uart_rx_word (
    input  logic        clk,
    input  logic        nRst,
    input  logic [7:0]  uart_byte,
    input  logic        uart_strobe,
    output logic [31:0] uart_word
);

    logic [23:0] rx_count;
    logic [7:0]  last_byte;

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            rx_count  <= 24'b0;
            last_byte <= 8'b0;
        end else if (uart_strobe) begin
            rx_count  <= rx_count + 24'd1;
            last_byte <= uart_byte;
        end
    end

    // count in the upper bits, newest byte below
    assign uart_word = {rx_count, last_byte};

endmodule

/* source/shared_memory.sv */
`timescale 1ns/1ps

module shared_memory import mem_share_pkg::*; (
    input  logic        clk,
    input  logic        nRst,
    input  logic        mem_busy,
    input  mem_req_t    mem_req,
    output logic [31:0] rdata
);

    logic [31:0]       mem [MEM_WORDS];
    logic [MEM_AW-1:0] idx;

    // byte address to word index, wraps at the depth
    assign idx = mem_req.adr[MEM_AW+1:2];

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = 32'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!mem_busy && mem_req.write) begin
            for (int b = 0; b < 4; b++) begin
                if (mem_req.sel[b]) begin
                    mem[idx][8*b +: 8] <= mem_req.wdata[8*b +: 8];
                end
            end
        end
    end

    // read word held until the next accepted read
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            rdata <= 32'b0;
        end else if (!mem_busy && mem_req.read) begin
            rdata <= mem[idx];
        end
    end

endmodule

/* source/pixel_fifo.sv */
`timescale 1ns/1ps

module pixel_fifo import mem_share_pkg::*; (
    input  logic               clk,
    input  logic               nRst,
    input  logic               push,
    input  logic [31:0]        push_data,
    input  logic               pop,
    output logic [31:0]        head,
    output logic               not_empty,
    output logic [FIFO_CW-1:0] free
);

    logic [31:0]        entries [FIFO_DEPTH];
    logic [FIFO_PW-1:0] wr_ptr;
    logic [FIFO_PW-1:0] rd_ptr;
    logic [FIFO_CW-1:0] count;
    logic               do_push;
    logic               do_pop;

    assign do_push = push && (count != FIFO_CW'(FIFO_DEPTH));
    // pop while empty is dropped
    assign do_pop  = pop && (count != '0);

    always_ff @(posedge clk) begin
        if (do_push) begin
            entries[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop) rd_ptr <= rd_ptr + 1'b1;
            count <= count + FIFO_CW'(do_push) - FIFO_CW'(do_pop);
        end
    end

    // show-ahead output
    assign head      = entries[rd_ptr];
    assign not_empty = (count != '0);
    assign free      = FIFO_CW'(FIFO_DEPTH) - count;

endmodule

/* source/vga_fetcher.sv */
`timescale 1ns/1ps

module vga_fetcher import mem_share_pkg::*; (
    input  logic               clk,
    input  logic               nRst,
    input  logic               frame_start,
    input  logic               vga_grant,
    input  logic               vga_enable,
    input  logic [31:0]        vga_data,
    input  logic [FIFO_CW-1:0] fifo_free,
    output vga_state_t         vga_state,
    output logic               vga_read,
    output logic [31:0]        vga_adr,
    output logic               push,
    output logic [31:0]        push_data
);

    vga_state_t          state;
    vga_state_t          state_d;
    logic [31:0]         issue_adr;
    logic [FRAME_CW-1:0] ret_cnt;
    logic                start;
    logic                last_ret;

    assign start    = (state == INACTIVE) && frame_start;
    assign last_ret = vga_enable && (ret_cnt == FRAME_CW'(FRAME_WORDS - 1));

    always_comb begin
        state_d = state;
        case (state)
            INACTIVE: if (frame_start) state_d = READY;
            READY:    state_d = ACTIVE;
            ACTIVE:   if (last_ret) state_d = INACTIVE;
            default:  state_d = INACTIVE;
        endcase
    end

    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            state     <= INACTIVE;
            issue_adr <= FRAME_BASE;
            ret_cnt   <= '0;
        end else begin
            state <= state_d;
            if (start) begin
                issue_adr <= FRAME_BASE;
                ret_cnt   <= '0;
            end else begin
                if (vga_grant) begin
                    issue_adr <= issue_adr + 32'd4;
                end
                if (vga_enable) begin
                    ret_cnt <= ret_cnt + 1'b1;
                end
            end
        end
    end

    // one word may still be in flight, so keep a spare entry
    assign vga_read  = (state == ACTIVE) && (issue_adr != FRAME_END)
                       && (fifo_free > FIFO_CW'(1));
    assign vga_adr   = issue_adr;
    assign vga_state = state;

    assign push      = vga_enable && (state == ACTIVE);
    assign push_data = vga_data;

endmodule

/* source/request_handler.sv */
`timescale 1ns/1ps

module request_handler import mem_share_pkg::*; (
    input  logic        clk,
    input  logic        nRst,

    // stall from the memory side
    input  logic        mem_busy,

    // display fetcher
    input  vga_state_t  vga_state,
    input  logic        vga_read,
    input  logic [31:0] vga_adr,
    output logic        vga_grant,
    output logic        vga_enable,
    output logic [31:0] vga_data,

    // cpu ports
    input  cpu_req_t    cpu_req,
    output logic        cpu_enable,
    output logic [31:0] instr_data,
    output logic [31:0] cpu_data,

    // uart holding word
    input  logic [31:0] uart_word,

    // shared memory
    input  logic [31:0] rdata,
    output mem_req_t    mem_req
);

    client_t     next_client;
    client_t     current_client;
    client_t     next_client_d;
    mem_req_t    slot_req;
    logic        slot_access;
    logic        issued_q;
    logic        uart_hit;
    logic        uart_hit_q;
    logic        resp_slot;
    logic        instr_resp;
    logic [31:0] instruction;

    assign uart_hit = (cpu_req.data_adr == UART_ADDRESS);

    // slot rotation
    always_comb begin
        next_client_d = next_client;
        case (next_client)
            VGA: begin
                if (vga_state == READY || vga_state == ACTIVE) begin
                    next_client_d = VGA;
                end else begin
                    next_client_d = CPU_INSTR;
                end
            end
            CPU_INSTR: begin
                next_client_d = CPU_DATA;
            end
            default: begin
                if (vga_state == INACTIVE) begin
                    next_client_d = CPU_INSTR;
                end else begin
                    next_client_d = VGA;
                end
            end
        endcase
    end

    // request of the slot owner, before the stall gate
    always_comb begin
        slot_req    = '0;
        slot_access = 1'b0;
        case (next_client)
            VGA: begin
                slot_req.read = vga_read;
                slot_req.adr  = vga_adr;
                slot_req.sel  = 4'b1111;
                slot_access   = vga_read;
            end
            CPU_INSTR: begin
                slot_req.read = 1'b1;
                slot_req.adr  = cpu_req.instr_adr;
                slot_req.sel  = 4'b1111;
                slot_access   = 1'b1;
            end
            default: begin
                // uart word is answered here, memory stays idle
                if (!uart_hit) begin
                    slot_req.read  = cpu_req.read;
                    slot_req.write = cpu_req.write;
                    slot_req.adr   = cpu_req.data_adr;
                    slot_req.wdata = cpu_req.wdata;
                    slot_req.sel   = cpu_req.sel;
                end
                slot_access = cpu_req.read | cpu_req.write;
            end
        endcase
    end

    assign mem_req   = mem_busy ? '0 : slot_req;
    assign vga_grant = !mem_busy && (next_client == VGA) && vga_read;

    // slot and response state, frozen during a stall
    always_ff @(posedge clk, negedge nRst) begin
        if (!nRst) begin
            next_client    <= VGA;
            current_client <= VGA;
            issued_q       <= 1'b0;
            uart_hit_q     <= 1'b0;
            instruction    <= 32'b0;
        end else if (!mem_busy) begin
            next_client    <= next_client_d;
            current_client <= next_client;
            issued_q       <= slot_access;
            uart_hit_q     <= uart_hit;
            if (instr_resp) begin
                instruction <= rdata;
            end
        end
    end

    // answer of the previous accepted slot
    assign resp_slot  = !mem_busy && issued_q;
    assign vga_enable = resp_slot && (current_client == VGA);
    assign cpu_enable = resp_slot && (current_client == CPU_DATA);
    assign instr_resp = resp_slot && (current_client == CPU_INSTR);

    assign vga_data   = vga_enable ? rdata : 32'b0;
    assign instr_data = instr_resp ? rdata : instruction;

    always_comb begin
        cpu_data = 32'b0;
        if (cpu_enable) begin
            cpu_data = uart_hit_q ? uart_word : rdata;
        end
    end

endmodule

/* source/mem_share_top.sv */
`timescale 1ns/1ps

module mem_share_top import mem_share_pkg::*; (
    input  logic        clk,
    input  logic        nRst,
    input  logic        mem_busy,
    input  logic        frame_start,
    input  logic        pixel_pop,
    input  cpu_req_t    cpu_req,
    input  logic [7:0]  uart_byte,
    input  logic        uart_strobe,
    output logic [31:0] instr_data,
    output logic [31:0] cpu_data,
    output logic        cpu_enable,
    output logic [31:0] pixel_word,
    output logic        pixel_valid,
    output vga_state_t  vga_state
);

    mem_req_t           mem_req;
    logic [31:0]        rdata;
    logic               vga_read;
    logic [31:0]        vga_adr;
    logic               vga_grant;
    logic               vga_enable;
    logic [31:0]        vga_data;
    logic               push;
    logic [31:0]        push_data;
    logic [FIFO_CW-1:0] fifo_free;
    logic [31:0]        uart_word;

    request_handler request_handler_inst (
        .clk        (clk),
        .nRst       (nRst),
        .mem_busy   (mem_busy),
        .vga_state  (vga_state),
        .vga_read   (vga_read),
        .vga_adr    (vga_adr),
        .vga_grant  (vga_grant),
        .vga_enable (vga_enable),
        .vga_data   (vga_data),
        .cpu_req    (cpu_req),
        .cpu_enable (cpu_enable),
        .instr_data (instr_data),
        .cpu_data   (cpu_data),
        .uart_word  (uart_word),
        .rdata      (rdata),
        .mem_req    (mem_req)
    );

    vga_fetcher vga_fetcher_inst (
        .clk         (clk),
        .nRst        (nRst),
        .frame_start (frame_start),
        .vga_grant   (vga_grant),
        .vga_enable  (vga_enable),
        .vga_data    (vga_data),
        .fifo_free   (fifo_free),
        .vga_state   (vga_state),
        .vga_read    (vga_read),
        .vga_adr     (vga_adr),
        .push        (push),
        .push_data   (push_data)
    );

    pixel_fifo pixel_fifo_inst (
        .clk       (clk),
        .nRst      (nRst),
        .push      (push),
        .push_data (push_data),
        .pop       (pixel_pop),
        .head      (pixel_word),
        .not_empty (pixel_valid),
        .free      (fifo_free)
    );

    shared_memory shared_memory_inst (
        .clk      (clk),
        .nRst     (nRst),
        .mem_busy (mem_busy),
        .mem_req  (mem_req),
        .rdata    (rdata)
    );

    uart_rx_word uart_rx_word_inst (
        .clk         (clk),
        .nRst        (nRst),
        .uart_byte   (uart_byte),
        .uart_strobe (uart_strobe),
        .uart_word   (uart_word)
    );

endmodule

/* dv/mem_share_assertions.sv */
`timescale 1ns/1ps

module mem_share_assertions import mem_share_pkg::*; (
    input logic     clk,
    input logic     nRst,
    input logic     mem_busy,
    input client_t  next_client,
    input cpu_req_t cpu_req,
    input mem_req_t mem_req,
    input logic     cpu_enable,
    input logic     vga_enable
);

    int fail_count;

    read_write_excl: assert property (
        @(posedge clk) disable iff (!nRst) !(mem_req.read && mem_req.write)
    ) else begin
        $error("memory read and write are high together");
        fail_count++;
    end

    // a stalled cycle must leave the memory idle
    idle_when_busy: assert property (
        @(posedge clk) disable iff (!nRst) mem_busy |-> !(mem_req.read || mem_req.write)
    ) else begin
        $error("memory request issued while busy");
        fail_count++;
    end

    uart_no_mem: assert property (
        @(posedge clk) disable iff (!nRst)
        (next_client == CPU_DATA && cpu_req.data_adr == UART_ADDRESS)
            |-> !(mem_req.read || mem_req.write)
    ) else begin
        $error("uart slot reached the memory");
        fail_count++;
    end

    one_enable: assert property (
        @(posedge clk) disable iff (!nRst) !(cpu_enable && vga_enable)
    ) else begin
        $error("cpu_enable and vga_enable are high together");
        fail_count++;
    end

endmodule

/* dv/mem_share_checker.sv */
`timescale 1ns/1ps

module mem_share_checker import mem_share_pkg::*; (
    input  logic        clk,
    input  logic        nRst,
    input  logic        mem_busy,
    input  logic        frame_start,
    input  logic        pixel_pop,
    input  cpu_req_t    cpu_req,
    input  logic [7:0]  uart_byte,
    input  logic        uart_strobe,
    input  logic [31:0] instr_data,
    input  logic [31:0] cpu_data,
    input  logic        cpu_enable,
    input  logic [31:0] pixel_word,
    input  logic        pixel_valid,
    input  vga_state_t  vga_state,
    input  logic        run_done,
    output int          checks,
    output int          errors
);

    logic [31:0] model [MEM_WORDS];
    logic [31:0] frame_q [$];
    cpu_req_t    issued_req;
    logic [23:0] rx_count;
    logic [7:0]  rx_byte;
    logic [31:0] last_instr_adr;
    int          settle;
    int          idx;
    logic        closed;

    // word index of a byte address modulo the memory depth
    function automatic int word_index(input logic [31:0] adr);
        return int'((adr >> 2) % 32'(MEM_WORDS));
    endfunction

    task automatic report_problem(input string msg);
        errors++;
        $display("ERROR at %0t: %s", $time, msg);
    endtask

    task automatic check_true(input logic cond, input string msg);
        checks++;
        if (!cond) begin
            errors++;
            $display("CHECK FAILED at %0t: %s", $time, msg);
        end
    endtask

    task automatic compare_word(input logic [31:0] got, input logic [31:0] exp,
                                input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // compared mid-cycle, half a period after the inputs change
    always @(negedge clk) begin
        if (!nRst) begin
            check_true(!cpu_enable && !pixel_valid && vga_state == INACTIVE,
                       "outputs not idle in reset");
            foreach (model[w]) begin
                model[w] = 32'b0;
            end
            frame_q.delete();
            issued_req     = '0;
            rx_count       = 24'b0;
            rx_byte        = 8'b0;
            last_instr_adr = cpu_req.instr_adr;
            settle         = 0;
            closed         = 1'b0;
        end else begin
            if (cpu_enable) begin
                check_true(!mem_busy, "cpu_enable while memory busy");
                idx = word_index(issued_req.data_adr);
                if (issued_req.read && issued_req.data_adr == UART_ADDRESS) begin
                    compare_word(cpu_data, {rx_count, rx_byte}, "uart read");
                end else if (issued_req.read) begin
                    compare_word(cpu_data, model[idx], "data read");
                end else if (issued_req.write) begin
                    // uart writes never reach the memory
                    if (issued_req.data_adr != UART_ADDRESS) begin
                        for (int b = 0; b < 4; b++) begin
                            if (issued_req.sel[b]) begin
                                model[idx][8*b +: 8] = issued_req.wdata[8*b +: 8];
                            end
                        end
                    end
                    settle = 0;
                end else begin
                    report_problem("cpu_enable without a cpu request");
                end
            end
            // request of the last accepted cycle is the one answered next
            if (!mem_busy) begin
                issued_req = cpu_req;
            end

            // instruction word once a full rotation has passed
            if (cpu_req.instr_adr != last_instr_adr || vga_state != INACTIVE) begin
                settle = 0;
            end else if (!mem_busy) begin
                settle++;
            end
            last_instr_adr = cpu_req.instr_adr;
            if (settle >= 6) begin
                compare_word(instr_data, model[word_index(cpu_req.instr_adr)], "instruction");
            end

            if (frame_start && vga_state == INACTIVE) begin
                frame_q.delete();
                for (int w = 0; w < FRAME_WORDS; w++) begin
                    frame_q.push_back(model[word_index(FRAME_BASE + 32'(4 * w))]);
                end
            end
            if (pixel_pop && pixel_valid) begin
                if (frame_q.size() == 0) begin
                    report_problem("pixel word popped with no display word expected");
                end else begin
                    compare_word(pixel_word, frame_q.pop_front(), "display word");
                    // last word out means the whole frame was fetched
                    if (frame_q.size() == 0) begin
                        check_true(vga_state == INACTIVE,
                                   "display fetcher did not go back to INACTIVE");
                    end
                end
            end

            if (uart_strobe) begin
                rx_count = rx_count + 24'd1;
                rx_byte  = uart_byte;
            end

            if (run_done && !closed) begin
                closed = 1'b1;
                check_true(frame_q.size() == 0,
                           $sformatf("%0d display words never popped", frame_q.size()));
            end
        end
    end

endmodule

/* dv/mem_share_tb.sv */
`timescale 1ns/1ps

module mem_share_tb import mem_share_pkg::*; ();

    // one step of stimulus
    typedef struct packed {
        cpu_req_t    req;
        logic        stall;
        logic [7:0]  uart_byte;
        logic        uart_send;
        logic        frame;
        logic [15:0] cycles;
    } row_t;

    logic        clk;
    logic        nRst;
    logic        mem_busy;
    logic        frame_start;
    logic        pixel_pop = 1'b0;
    cpu_req_t    cpu_req;
    logic [7:0]  uart_byte;
    logic        uart_strobe;
    logic [31:0] instr_data;
    logic [31:0] cpu_data;
    logic        cpu_enable;
    logic [31:0] pixel_word;
    logic        pixel_valid;
    vga_state_t  vga_state;
    logic        run_done = 1'b0;
    int          checks;
    int          errors;
    int          assert_fails;
    row_t        rows [$];
    logic [31:0] seed = 32'hb0c8;
    int          cycle_limit = 0;
    int          cycle_count = 0;

    mem_share_top mem_share_top_inst (
        .clk         (clk),
        .nRst        (nRst),
        .mem_busy    (mem_busy),
        .frame_start (frame_start),
        .pixel_pop   (pixel_pop),
        .cpu_req     (cpu_req),
        .uart_byte   (uart_byte),
        .uart_strobe (uart_strobe),
        .instr_data  (instr_data),
        .cpu_data    (cpu_data),
        .cpu_enable  (cpu_enable),
        .pixel_word  (pixel_word),
        .pixel_valid (pixel_valid),
        .vga_state   (vga_state)
    );

    mem_share_checker mem_share_checker_inst (
        .clk         (clk),
        .nRst        (nRst),
        .mem_busy    (mem_busy),
        .frame_start (frame_start),
        .pixel_pop   (pixel_pop),
        .cpu_req     (cpu_req),
        .uart_byte   (uart_byte),
        .uart_strobe (uart_strobe),
        .instr_data  (instr_data),
        .cpu_data    (cpu_data),
        .cpu_enable  (cpu_enable),
        .pixel_word  (pixel_word),
        .pixel_valid (pixel_valid),
        .vga_state   (vga_state),
        .run_done    (run_done),
        .checks      (checks),
        .errors      (errors)
    );

    bind request_handler mem_share_assertions assertions_inst (
        .clk         (clk),
        .nRst        (nRst),
        .mem_busy    (mem_busy),
        .next_client (next_client),
        .cpu_req     (cpu_req),
        .mem_req     (mem_req),
        .cpu_enable  (cpu_enable),
        .vga_enable  (vga_enable)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // pixel reader, one pop every other cycle
    always @(posedge clk) begin
        pixel_pop <= pixel_valid && !pixel_pop;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("timeout: run did not finish within %0d cycles", cycle_limit);
            $display("TEST FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic cpu_req_t wr_req(input logic [31:0] iadr, input logic [31:0] dadr,
                                        input logic [31:0] wdata, input logic [3:0] sel);
        cpu_req_t r;
        r           = '0;
        r.instr_adr = iadr;
        r.data_adr  = dadr;
        r.write     = 1'b1;
        r.wdata     = wdata;
        r.sel       = sel;
        return r;
    endfunction

    function automatic cpu_req_t rd_req(input logic [31:0] iadr, input logic [31:0] dadr);
        cpu_req_t r;
        r           = '0;
        r.instr_adr = iadr;
        r.data_adr  = dadr;
        r.read      = 1'b1;
        r.sel       = 4'hf;
        return r;
    endfunction

    task automatic add_row(input cpu_req_t req, input logic stall, input logic [7:0] ub,
                           input logic send, input logic frame, input logic [15:0] cycles);
        row_t r;
        r.req       = req;
        r.stall     = stall;
        r.uart_byte = ub;
        r.uart_send = send;
        r.frame     = frame;
        r.cycles    = cycles;
        rows.push_back(r);
    endtask

    task automatic build_table();
        add_row('0, 1'b0, 8'h00, 1'b0, 1'b0, 16'd4);
        // round trips, full word then single lanes
        add_row(wr_req(32'h0, 32'h10, 32'hdead_beef, 4'hf), 1'b0, 8'h00, 1'b0, 1'b0, 16'd8);
        add_row(rd_req(32'h10, 32'h10), 1'b0, 8'h00, 1'b0, 1'b0, 16'd8);
        add_row(wr_req(32'h10, 32'h10, 32'h0000_a500, 4'b0010), 1'b0, 8'h00, 1'b0, 1'b0, 16'd8);
        add_row(rd_req(32'h10, 32'h10), 1'b0, 8'h00, 1'b0, 1'b0, 16'd8);
        add_row(wr_req(32'h14, 32'h14, 32'h1234_5678, 4'b1001), 1'b0, 8'h00, 1'b0, 1'b0, 16'd8);
        add_row(rd_req(32'h10, 32'h14), 1'b0, 8'h00, 1'b0, 1'b0, 16'd8);
        // uart word and its memory alias
        add_row(rd_req(32'h14, UART_ADDRESS), 1'b0, 8'h5a, 1'b1, 1'b0, 16'd8);
        add_row(rd_req(32'h14, UART_ADDRESS), 1'b0, 8'hc3, 1'b1, 1'b0, 16'd8);
        add_row(wr_req(32'h14, UART_ADDRESS, 32'hffff_ffff, 4'hf), 1'b0, 8'h00, 1'b0, 1'b0, 16'd8);
        add_row(rd_req(32'h14, 32'd1524), 1'b0, 8'h00, 1'b0, 1'b0, 16'd8);
        for (int i = 0; i < FRAME_WORDS; i++) begin
            add_row(wr_req(32'h10, FRAME_BASE + 32'(4 * i), 32'hc0de_0000 + 32'(i * 7), 4'hf),
                    1'b0, 8'h00, 1'b0, 1'b0, 16'd6);
        end
        add_row(rd_req(32'h14, 32'h10), 1'b0, 8'h00, 1'b0, 1'b1, 16'd120);
        add_row(rd_req(32'h0, 32'h14), 1'b0, 8'h00, 1'b0, 1'b0, 16'd8);
        // same traffic with random stalls
        add_row(wr_req(32'h20, 32'h20, 32'ha5a5_5a5a, 4'b1100), 1'b1, 8'h00, 1'b0, 1'b0, 16'd12);
        add_row(rd_req(32'h20, 32'h20), 1'b1, 8'h00, 1'b0, 1'b0, 16'd12);
        add_row(rd_req(32'h20, UART_ADDRESS), 1'b1, 8'h7e, 1'b1, 1'b0, 16'd12);
        add_row(wr_req(32'h20, 32'h20, 32'h0000_0077, 4'b0001), 1'b1, 8'h00, 1'b0, 1'b0, 16'd12);
        add_row(rd_req(32'h10, 32'h20), 1'b1, 8'h00, 1'b0, 1'b0, 16'd12);
        add_row(wr_req(32'h24, 32'h24, 32'h600d_f00d, 4'hf), 1'b1, 8'h00, 1'b0, 1'b1, 16'd200);
        add_row(rd_req(32'h118, 32'h24), 1'b1, 8'h00, 1'b0, 1'b0, 16'd16);
        add_row(rd_req(32'h24, FRAME_BASE + 32'h4), 1'b1, 8'h00, 1'b0, 1'b0, 16'd16);
        add_row('0, 1'b0, 8'h00, 1'b0, 1'b0, 16'd8);
    endtask

    task automatic apply_row(input row_t r);
        for (int n = 0; n < int'(r.cycles); n++) begin
            @(posedge clk);
            cpu_req     <= r.req;
            uart_byte   <= r.uart_byte;
            uart_strobe <= r.uart_send && (n == 0);
            frame_start <= r.frame && (n == 0);
            if (r.stall) begin
                seed = xorshift(seed);
                mem_busy <= (seed[1:0] == 2'b00);
            end else begin
                mem_busy <= 1'b0;
            end
        end
    endtask

    initial begin
        nRst        = 1'b0;
        mem_busy    = 1'b0;
        frame_start = 1'b0;
        cpu_req     = '0;
        uart_byte   = 8'h00;
        uart_strobe = 1'b0;
        build_table();
        foreach (rows[i]) begin
            cycle_limit += int'(rows[i].cycles);
        end
        cycle_limit = cycle_limit * 4 + 200;

        repeat (5) @(posedge clk);
        nRst <= 1'b1;
        foreach (rows[i]) begin
            apply_row(rows[i]);
        end

        @(posedge clk);
        cpu_req     <= '0;
        mem_busy    <= 1'b0;
        frame_start <= 1'b0;
        uart_strobe <= 1'b0;
        // wait for the display to drain
        while (vga_state != INACTIVE || pixel_valid) begin
            @(posedge clk);
        end
        run_done <= 1'b1;
        repeat (2) @(posedge clk);

        assert_fails = mem_share_top_inst.request_handler_inst.assertions_inst.fail_count;
        $display("checks run: %0d, check errors: %0d, assertion failures: %0d",
                 checks, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* files.f */
source/mem_share_pkg.sv
source/uart_rx_word.sv
source/shared_memory.sv
source/pixel_fifo.sv
source/vga_fetcher.sv
source/request_handler.sv
source/mem_share_top.sv
dv/mem_share_assertions.sv
dv/mem_share_checker.sv
dv/mem_share_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f files.f --top-module mem_share_tb -o mem_share_sim
./obj_dir/mem_share_sim +verilator+error+limit+100 | tee sim.log

if grep -q "TEST PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
